/* Bender.yml */
package:
  name: nf_cpu

export_include_dirs:
  - src

sources:
  - files:
      - src/nf_pkg.sv
      - src/nf_control_unit.sv
      - src/nf_alu.sv
      - src/nf_reg_file.sv
      - src/nf_clock_div.sv
      - src/nf_pc_unit.sv
      - src/nf_cpu.sv
  - target: simulation
    files:
      - dv/nf_cpu_tb.sv

/* dv/nf_cpu_tb.sv */
/*
 * testbench for the single-cycle core
 * instruction and data memory models, program assembler
 * reference model, pc and store monitors, register readback
 */

`include "nf_config.svh"

module nf_cpu_tb;

    logic clk = 1'b0;
    logic rst;
    nf_pkg::div_t div;
    nf_pkg::word_t instr_addr, addr_dm, wd_dm, reg_data, rng;
    logic we_dm;
    nf_pkg::reg_addr_t reg_addr;
    nf_pkg::word_t imem [256];
    nf_pkg::word_t dmem [256];
    nf_pkg::word_t mr [32];
    nf_pkg::word_t md [256];
    nf_pkg::word_t exp_pc [$];
    nf_pkg::word_t st_addr [$];
    nf_pkg::word_t st_data [$];
    nf_pkg::word_t halt_pc;
    int n_instr;
    int errors = 0;

    always #50 clk = ~clk;

    nf_cpu nf_cpu_i (
        .clk(clk), .rst(rst), .div(div), .instr_addr(instr_addr),
        .instr(imem[instr_addr[9:2]]), .addr_dm(addr_dm), .we_dm(we_dm),
        .wd_dm(wd_dm), .rd_dm(dmem[addr_dm[9:2]]), .reg_addr(reg_addr),
        .reg_data(reg_data)
    );

    always @(posedge clk) begin
        if (we_dm) begin
            dmem[addr_dm[9:2]] <= wd_dm;
        end
    end

    // a store lasts one cycle whenever steps are spaced out
    assert property (@(posedge clk) disable iff (rst) (div != '0 && we_dm) |=> !we_dm)
        else begin
            errors = errors + 1;
            $display("we_dm stayed high for two cycles in a row");
        end

    function automatic nf_pkg::word_t xorshift(input nf_pkg::word_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic nf_pkg::word_t enc_r(input logic [6:0] f7, input int rs2, rs1,
                                            input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `NF_OP_R};
    endfunction

    function automatic nf_pkg::word_t enc_i(input logic [11:0] imm, input int rs1,
                                            input logic [2:0] f3, input int rd,
                                            input logic [6:0] op);
        return {imm, rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic nf_pkg::word_t enc_s(input logic [11:0] imm, input int rs2, rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `NF_OP_STORE};
    endfunction

    function automatic nf_pkg::word_t enc_b(input logic [12:0] imm, input int rs2, rs1,
                                            input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11],
                `NF_OP_BRANCH};
    endfunction

    task automatic emit(input nf_pkg::word_t w);
        imem[n_instr] = w;
        n_instr = n_instr + 1;
    endtask

    task automatic build_program();
        n_instr = 0;
        rng = 32'h8138;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        for (int r = 1; r < 16; r++) begin
            rng = xorshift(rng);
            emit({rng[31:12], 5'(r), `NF_OP_LUI});
            emit(enc_i(rng[11:0], r, 3'b000, r, `NF_OP_I));
        end
        emit(enc_r(7'h00, 2, 1, 3'b000, 16));
        emit(enc_r(7'h20, 4, 3, 3'b000, 17));
        emit(enc_r(7'h00, 6, 5, 3'b111, 18));
        emit(enc_r(7'h00, 8, 7, 3'b110, 19));
        emit(enc_r(7'h00, 10, 9, 3'b100, 20));
        emit(enc_r(7'h00, 12, 11, 3'b001, 21));
        emit(enc_r(7'h00, 14, 13, 3'b101, 22));
        emit(enc_r(7'h00, 15, 1, 3'b010, 23));
        emit(enc_i(12'h7ff, 2, 3'b000, 24, `NF_OP_I));
        emit(enc_i(12'h0f3, 3, 3'b111, 25, `NF_OP_I));
        emit(enc_i(12'h804, 4, 3'b110, 26, `NF_OP_I));
        emit(enc_i(12'hfff, 5, 3'b100, 27, `NF_OP_I));
        emit(enc_i(12'h007, 6, 3'b001, 28, `NF_OP_I));
        emit(enc_i(12'h00d, 7, 3'b101, 29, `NF_OP_I));
        emit(enc_i(12'h800, 8, 3'b010, 30, `NF_OP_I));
        emit({20'habcde, 5'd31, `NF_OP_LUI});
        emit(enc_i(12'h005, 1, 3'b000, 0, `NF_OP_I));
        emit(enc_s(12'h040, 16, 0));
        emit(enc_s(12'h044, 17, 0));
        emit(enc_s(12'h048, 18, 0));
        emit(enc_i(12'h040, 0, 3'b010, 5, `NF_OP_LOAD));
        emit(enc_i(12'h044, 0, 3'b010, 8, `NF_OP_LOAD));
        // taken and not-taken forms of beq and bne
        emit(enc_b(13'd8, 1, 1, 3'b000));
        emit(enc_i(12'h001, 0, 3'b000, 6, `NF_OP_I));
        emit(enc_b(13'd8, 1, 1, 3'b001));
        emit(enc_i(12'h002, 0, 3'b000, 9, `NF_OP_I));
        emit(enc_b(13'd8, 2, 1, 3'b000));
        emit(enc_i(12'h003, 0, 3'b000, 10, `NF_OP_I));
        emit(enc_b(13'd8, 2, 1, 3'b001));
        emit(enc_i(12'h004, 0, 3'b000, 7, `NF_OP_I));
        emit(enc_b(13'd0, 0, 0, 3'b000));
    endtask

    // behavioral ISA model that records next pcs and stores
    task automatic run_model();
        nf_pkg::word_t pc, npc, ins, a, b, res, imm_i, imm_s, imm_b;
        logic [6:0] op;
        logic [2:0] f3;
        logic [4:0] rd;
        exp_pc.delete();
        st_addr.delete();
        st_data.delete();
        pc = '0;
        for (int i = 0; i < 32; i++) begin
            mr[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            md[i] = 32'hc0de0000 ^ (i * 32'h01000193);
            dmem[i] = md[i];
        end
        for (int k = 0; k < 1000; k++) begin
            ins = imem[pc[9:2]];
            op = ins[6:0];
            f3 = ins[14:12];
            rd = ins[11:7];
            a = mr[ins[19:15]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            b = (op == `NF_OP_I) ? imm_i : mr[ins[24:20]];
            npc = pc + 4;
            res = '0;
            case (f3)
                3'd0: res = (op == `NF_OP_R && ins[30]) ? a - b : a + b;
                3'd1: res = a << b[4:0];
                3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd4: res = a ^ b;
                3'd5: res = a >> b[4:0];
                3'd6: res = a | b;
                3'd7: res = a & b;
                default: res = '0;
            endcase
            if (op == `NF_OP_LUI) begin
                res = {ins[31:12], 12'b0};
            end else if (op == `NF_OP_LOAD) begin
                res = md[(a + imm_i) >> 2];
            end
            if ((op == `NF_OP_R || op == `NF_OP_I || op == `NF_OP_LUI ||
                 op == `NF_OP_LOAD) && rd != 0) begin
                mr[rd] = res;
            end
            if (op == `NF_OP_STORE) begin
                st_addr.push_back(a + imm_s);
                st_data.push_back(b);
                md[(a + imm_s) >> 2] = b;
            end
            if (op == `NF_OP_BRANCH && ((a == b) != f3[0])) begin
                npc = pc + imm_b;
            end
            if (npc == pc) begin
                break;
            end
            exp_pc.push_back(npc);
            pc = npc;
        end
        halt_pc = pc;
    endtask

    task automatic check_val(input string name, input nf_pkg::word_t exp, act);
        assert (exp === act) else begin
            errors = errors + 1;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic run_program(input nf_pkg::div_t d);
        nf_pkg::word_t last_pc;
        int gap;
        bit done;
        run_model();
        @(posedge clk);
        rst <= 1'b1;
        div <= d;
        // first reset edge has cleared the pc
        @(posedge clk);
        @(negedge clk);
        check_val("reset pc", '0, instr_addr);
        check_val("reset we_dm", '0, 32'(we_dm));
        @(posedge clk);
        rst <= 1'b0;
        last_pc = '0;
        gap = 0;
        done = 1'b0;
        for (int c = 0; c < 2000 && !done; c++) begin
            @(negedge clk);
            if (c == 0) begin
                check_val("reset release pc", '0, instr_addr);
                check_val("reset release we_dm", '0, 32'(we_dm));
            end
            if (we_dm) begin
                if (st_addr.size() == 0) begin
                    errors = errors + 1;
                    $display("store seen that the program does not make");
                end else begin
                    check_val("store addr", st_addr.pop_front(), addr_dm);
                    check_val("store data", st_data.pop_front(), wd_dm);
                end
            end
            if (instr_addr != last_pc) begin
                check_val("step pacing", 32'(d) + 1, gap);
                check_val("next pc", exp_pc.size() ? exp_pc.pop_front() : 'x, instr_addr);
                last_pc = instr_addr;
                gap = 0;
            end
            gap = gap + 1;
            done = (instr_addr == halt_pc) && (exp_pc.size() == 0);
        end
        if (!done) begin
            errors = errors + 1;
            $display("timeout: program never reached its halt address");
        end else begin
            for (int r = 0; r < 32; r++) begin
                @(posedge clk);
                reg_addr <= r[4:0];
                @(negedge clk);
                check_val($sformatf("register x%0d", r), mr[r], reg_data);
            end
            for (int i = 0; i < 256; i++) begin
                check_val($sformatf("dmem word %0d", i), md[i], dmem[i]);
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        div = '0;
        reg_addr = '0;
        build_program();
        run_program(26'd0);
        run_program(26'd3);
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : nf_cpu_tb

/* sim.f */
+incdir+src
src/nf_pkg.sv
src/nf_control_unit.sv
src/nf_alu.sv
src/nf_reg_file.sv
src/nf_clock_div.sv
src/nf_pc_unit.sv
src/nf_cpu.sv
dv/nf_cpu_tb.sv

/* src/nf_alu.sv */
/*
 * execute unit
 * add, sub, logic ops, shifts, signed compare, upper immediate pass
 */

module nf_alu (
    input  nf_pkg::word_t    a,
    input  nf_pkg::word_t    b,
    input  nf_pkg::alu_op_e  op,
    output nf_pkg::word_t    result,
    output logic             zero
);

    logic [4:0] shamt;

    // shift amount from the low bits of operand b
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            nf_pkg::ALU_ADD:      result = a + b;
            nf_pkg::ALU_SUB:      result = a - b;
            nf_pkg::ALU_AND:      result = a & b;
            nf_pkg::ALU_OR:       result = a | b;
            nf_pkg::ALU_XOR:      result = a ^ b;
            nf_pkg::ALU_SLL:      result = a << shamt;
            nf_pkg::ALU_SRL:      result = a >> shamt;
            nf_pkg::ALU_SLT: begin
                result    = '0;
                result[0] = $signed(a) < $signed(b);
            end
            nf_pkg::ALU_LUI_PASS: result = b;
            default:              result = '0;
        endcase
    end

    // used by beq/bne after sub
    assign zero = (result == '0);

endmodule : nf_alu

/* src/nf_clock_div.sv */
/*
 * step strobe generator
 * one pulse every div+1 clock cycles
 */

module nf_clock_div (
    input  logic          clk,
    input  logic          rst,
    input  nf_pkg::div_t  div,
    output logic          step
);

    nf_pkg::div_t cnt;

    assign step = (cnt == div);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (step) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule : nf_clock_div

/* src/nf_config.svh */
/*
 * core configuration macros
 * word and register widths, divider width
 * rv32i opcode values for the supported subset
 */

`ifndef NF_CONFIG_SVH
`define NF_CONFIG_SVH

// data path
`define NF_XLEN         32
`define NF_REG_CNT      32
`define NF_DIV_W        26

// major opcodes
`define NF_OP_R         7'b0110011
`define NF_OP_I         7'b0010011
`define NF_OP_LUI       7'b0110111
`define NF_OP_LOAD      7'b0000011
`define NF_OP_STORE     7'b0100011
`define NF_OP_BRANCH    7'b1100011

`endif

/* src/nf_control_unit.sv */
/*
 * instruction decode
 * control fields, register addresses and sign-extended immediate
 */

`include "nf_config.svh"

module nf_control_unit (
    input  nf_pkg::word_t         instr,
    output nf_pkg::ctrl_t         ctrl,
    output nf_pkg::decode_regs_t  regs,
    output nf_pkg::word_t         imm
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    nf_pkg::imm_fmt_e  imm_fmt;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign regs.rs1 = instr[19:15];
    assign regs.rs2 = instr[24:20];
    assign regs.rd  = instr[11:7];

    always_comb begin
        ctrl         = '0;
        ctrl.alu_op  = nf_pkg::ALU_ADD;
        imm_fmt      = nf_pkg::IMM_I;
        case (opcode)
            `NF_OP_R, `NF_OP_I: begin
                ctrl.src_b_reg = (opcode == `NF_OP_R);
                ctrl.we_rf     = 1'b1;
                case (funct3)
                    3'b000: begin
                        // only the register form has sub
                        if (opcode == `NF_OP_R && funct7[5]) begin
                            ctrl.alu_op = nf_pkg::ALU_SUB;
                        end
                    end
                    3'b001: ctrl.alu_op = nf_pkg::ALU_SLL;
                    3'b010: ctrl.alu_op = nf_pkg::ALU_SLT;
                    3'b100: ctrl.alu_op = nf_pkg::ALU_XOR;
                    3'b101: begin
                        ctrl.alu_op = nf_pkg::ALU_SRL;
                        // arithmetic shift not supported
                        ctrl.we_rf  = !funct7[5];
                    end
                    3'b110: ctrl.alu_op = nf_pkg::ALU_OR;
                    3'b111: ctrl.alu_op = nf_pkg::ALU_AND;
                    default: ctrl.we_rf = 1'b0;
                endcase
            end
            `NF_OP_LUI: begin
                ctrl.alu_op = nf_pkg::ALU_LUI_PASS;
                ctrl.we_rf  = 1'b1;
                imm_fmt     = nf_pkg::IMM_U;
            end
            `NF_OP_LOAD: begin
                // word loads only
                ctrl.we_rf       = (funct3 == 3'b010);
                ctrl.rf_from_mem = 1'b1;
            end
            `NF_OP_STORE: begin
                ctrl.we_dm = (funct3 == 3'b010);
                imm_fmt    = nf_pkg::IMM_S;
            end
            `NF_OP_BRANCH: begin
                // compare by subtraction so the zero flag decides
                ctrl.alu_op    = nf_pkg::ALU_SUB;
                ctrl.src_b_reg = 1'b1;
                ctrl.branch    = (funct3[2:1] == 2'b00);
                ctrl.branch_ne = funct3[0];
                imm_fmt        = nf_pkg::IMM_B;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (imm_fmt)
            nf_pkg::IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            nf_pkg::IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // branch offset with bit 0 already in place
            nf_pkg::IMM_B: imm = {{19{instr[31]}}, instr[31], instr[7],
                                  instr[30:25], instr[11:8], 1'b0};
            default:       imm = {instr[31:12], 12'b0};
        endcase
    end

endmodule : nf_control_unit

/* src/nf_cpu.sv */
/*
 * single-cycle rv32i subset core
 * decode, alu, register file, pc and step divider
 * operand b and writeback select, step-qualified write enables
 */

module nf_cpu (
    // clock and reset
    input  logic               clk,
    input  logic               rst,
    // step pacing
    input  nf_pkg::div_t       div,
    // instruction memory
    output nf_pkg::word_t      instr_addr,
    input  nf_pkg::word_t      instr,
    // data memory
    output nf_pkg::word_t      addr_dm,
    output logic               we_dm,
    output nf_pkg::word_t      wd_dm,
    input  nf_pkg::word_t      rd_dm,
    // debug register read
    input  nf_pkg::reg_addr_t  reg_addr,
    output nf_pkg::word_t      reg_data
);

    nf_pkg::ctrl_t         ctrl;
    nf_pkg::decode_regs_t  regs;
    nf_pkg::word_t         imm;
    nf_pkg::word_t         rd1;
    nf_pkg::word_t         rd2;
    nf_pkg::word_t         src_b;
    nf_pkg::word_t         alu_result;
    nf_pkg::word_t         wd3;
    logic                  zero;
    logic                  step;

    assign src_b = ctrl.src_b_reg ? rd2 : imm;
    assign wd3   = ctrl.rf_from_mem ? rd_dm : alu_result;

    // store path
    assign addr_dm = alu_result;
    assign wd_dm   = rd2;
    assign we_dm   = ctrl.we_dm && step;

    nf_control_unit nf_control_unit_0 (
        .instr      ( instr      ),
        .ctrl       ( ctrl       ),
        .regs       ( regs       ),
        .imm        ( imm        )
    );

    nf_reg_file nf_reg_file_0 (
        .clk        ( clk                  ),
        .ra1        ( regs.rs1             ),
        .ra2        ( regs.rs2             ),
        .wa3        ( regs.rd              ),
        .rd1        ( rd1                  ),
        .rd2        ( rd2                  ),
        .wd3        ( wd3                  ),
        .we3        ( ctrl.we_rf && step   ),
        .dbg_addr   ( reg_addr             ),
        .dbg_data   ( reg_data             )
    );

    nf_alu nf_alu_0 (
        .a          ( rd1          ),
        .b          ( src_b        ),
        .op         ( ctrl.alu_op  ),
        .result     ( alu_result   ),
        .zero       ( zero         )
    );

    nf_clock_div nf_clock_div_0 (
        .clk        ( clk   ),
        .rst        ( rst   ),
        .div        ( div   ),
        .step       ( step  )
    );

    nf_pc_unit nf_pc_unit_0 (
        .clk        ( clk             ),
        .rst        ( rst             ),
        .step       ( step            ),
        .branch     ( ctrl.branch     ),
        .branch_ne  ( ctrl.branch_ne  ),
        .zero       ( zero            ),
        .imm        ( imm             ),
        .pc         ( instr_addr      )
    );

endmodule : nf_cpu

/* src/nf_pc_unit.sv */
/*
 * program counter
 * sequential or branch target update on each step
 */

module nf_pc_unit (
    input  logic           clk,
    input  logic           rst,
    input  logic           step,
    input  logic           branch,
    input  logic           branch_ne,
    input  logic           zero,
    input  nf_pkg::word_t  imm,
    output nf_pkg::word_t  pc
);

    logic           taken;
    nf_pkg::word_t  pc_seq;
    nf_pkg::word_t  pc_tgt;

    // beq wants zero, bne wants not zero
    assign taken  = branch && (zero != branch_ne);
    assign pc_seq = pc + 32'd4;
    assign pc_tgt = pc + imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (step) begin
            pc <= taken ? pc_tgt : pc_seq;
        end
    end

endmodule : nf_pc_unit

/* src/nf_pkg.sv */
/*
 * shared core types
 * word, register index and divider vectors
 * alu operation and immediate format enums
 * decoded control and register address structs
 */

`include "nf_config.svh"

package nf_pkg;

    typedef logic [`NF_XLEN-1:0]             word_t;
    typedef logic [$clog2(`NF_REG_CNT)-1:0]  reg_addr_t;
    typedef logic [`NF_DIV_W-1:0]            div_t;

    typedef enum logic [3:0] {
        ALU_ADD      = 4'd0,
        ALU_SUB      = 4'd1,
        ALU_AND      = 4'd2,
        ALU_OR       = 4'd3,
        ALU_XOR      = 4'd4,
        ALU_SLL      = 4'd5,
        ALU_SRL      = 4'd6,
        ALU_SLT      = 4'd7,
        ALU_LUI_PASS = 4'd8
    } alu_op_e;

    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_S = 2'd1,
        IMM_B = 2'd2,
        IMM_U = 2'd3
    } imm_fmt_e;

    // control fields from decode
    typedef struct packed {
        alu_op_e    alu_op;
        logic       src_b_reg;
        logic       we_rf;
        logic       we_dm;
        logic       rf_from_mem;
        logic       branch;
        logic       branch_ne;
    } ctrl_t;

    typedef struct packed {
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
    } decode_regs_t;

endpackage : nf_pkg

/* src/nf_reg_file.sv */
/*
 * register file with x0 reading as zero
 * two operand reads, one debug read, one clocked write
 */

`include "nf_config.svh"

module nf_reg_file (
    input  logic               clk,
    input  nf_pkg::reg_addr_t  ra1,
    input  nf_pkg::reg_addr_t  ra2,
    input  nf_pkg::reg_addr_t  wa3,
    output nf_pkg::word_t      rd1,
    output nf_pkg::word_t      rd2,
    input  nf_pkg::word_t      wd3,
    input  logic               we3,
    input  nf_pkg::reg_addr_t  dbg_addr,
    output nf_pkg::word_t      dbg_data
);

    nf_pkg::word_t regs [`NF_REG_CNT];

    function automatic nf_pkg::word_t read_reg(input nf_pkg::reg_addr_t addr);
        return (addr == '0) ? '0 : regs[addr];
    endfunction

    assign rd1      = read_reg(ra1);
    assign rd2      = read_reg(ra2);
    assign dbg_data = read_reg(dbg_addr);

    always_ff @(posedge clk) begin
        if (we3 && wa3 != '0) begin
            regs[wa3] <= wd3;
        end
    end

endmodule : nf_reg_file
